// ==== sifhTop.f ====
source/sifhPkg.sv
source/binMapper.sv
source/hisBuilderFSM.sv
source/peakDetecter.sv
source/algebraicBlock.sv
source/sifhTop.sv
verification/clockGen.sv
verification/sifhTop_assert.sv
verification/sifhTb.sv

// ==== source/algebraicBlock.sv ====
`default_nettype none

module algebraicBlock (
    input  wire logic                               clk,
    input  wire logic                               rst,
    input  wire logic                               peakDone,
    input  wire logic                               hisNum,
    input  wire logic [sifhPkg::binIdxWidth-1:0]    peakIdx,
    output logic      [sifhPkg::stampWidth-1:0]     windowStart,
    output logic      [sifhPkg::stampWidth-1:0]     peakStamp,
    output logic                                    resultValid
);

    logic [sifhPkg::stampWidth:0]   rawStart;
    logic [sifhPkg::stampWidth-1:0] clampedStart;
    logic [sifhPkg::stampWidth-1:0] fineOffset;

    // coarse bin start minus 32, borrow in the top bit
    assign rawStart = {1'b0, peakIdx, {sifhPkg::coarseShift{1'b0}}} -
                      (sifhPkg::stampWidth + 1)'(sifhPkg::windowBack);

    // negative -> 0, past 896 -> 896
    always_comb begin
        if (rawStart[sifhPkg::stampWidth]) begin
            clampedStart = '0;
        end else if (rawStart > sifhPkg::windowMax) begin
            clampedStart = sifhPkg::stampWidth'(sifhPkg::windowMax);
        end else begin
            clampedStart = rawStart[sifhPkg::stampWidth-1:0];
        end
    end

    // fine bin centre relative to window start
    assign fineOffset = {peakIdx, {sifhPkg::fineShift{1'b0}}} +
                        sifhPkg::stampWidth'(1 << (sifhPkg::fineShift - 1));

    always_ff @(posedge clk) begin
        if (rst) begin
            windowStart <= '0;
            peakStamp   <= '0;
            resultValid <= 1'b0;
        end else begin
            resultValid <= peakDone && hisNum;
            if (peakDone && !hisNum) begin
                windowStart <= clampedStart;
            end
            // max 896 + 120 + 4, no overflow
            if (peakDone && hisNum) begin
                peakStamp <= windowStart + fineOffset;
            end
        end
    end

endmodule

`default_nettype wire

// ==== source/binMapper.sv ====
`default_nettype none

module binMapper (
    input  wire logic                               clk,
    input  wire logic                               rst,
    input  wire logic                               sampleAccept,
    input  wire logic [sifhPkg::stampWidth-1:0]     roughData,
    input  wire logic [sifhPkg::stampWidth-1:0]     windowStart,
    input  wire logic                               hisNum,
    output logic                                    binValid,
    output logic      [sifhPkg::binIdxWidth-1:0]    binIdx
);

    sifhPkg::offsetWord_t offset;
    logic                 inWindow;
    logic [sifhPkg::binIdxWidth-1:0] nextIdx;

    // coarse pass uses the raw stamp
    // fine pass subtracts the window start, borrow lands in the top bit
    always_comb begin
        if (hisNum) begin
            offset.word = {1'b0, roughData} - {1'b0, windowStart};
        end else begin
            offset.word = {1'b0, roughData};
        end
    end

    // only fine samples can fall outside
    // below the window -> borrow, above it -> excess bits
    assign inWindow = !hisNum ||
                      (!offset.fineView.borrow && (offset.fineView.excess == '0));

    // view picked by pass
    assign nextIdx = hisNum ? offset.fineView.bin : offset.coarseView.bin;

    always_ff @(posedge clk) begin
        if (rst) begin
            binValid <= 1'b0;
        end else begin
            binValid <= sampleAccept && inWindow;
        end
    end

    // index is payload, qualified by binValid
    always_ff @(posedge clk) begin
        if (sampleAccept) begin
            binIdx <= nextIdx;
        end
    end

endmodule

`default_nettype wire

// ==== source/hisBuilderFSM.sv ====
`default_nettype none

module hisBuilderFSM (
    input  wire logic                               clk,
    input  wire logic                               rst,
    input  wire logic                               wrEn,
    output logic                                    acqActive,
    output logic                                    sampleAccept,
    input  wire logic                               binValid,
    input  wire logic [sifhPkg::binIdxWidth-1:0]    binIdx,
    output logic                                    acqCountFinish,
    output logic                                    hisNum,
    input  wire logic [sifhPkg::binIdxWidth-1:0]    scanAddr,
    input  wire logic                               scanClear,
    output logic      [sifhPkg::peakMax-1:0]        scanCount,
    input  wire logic                               peakDone
);

    logic [1:0]                         state;
    logic [sifhPkg::acceptWidth-1:0]    acceptCount;
    logic [sifhPkg::peakMax-1:0]        binCount [sifhPkg::numBins];

    // sampling window is the ACQUIRE state itself
    assign acqActive    = (state == sifhPkg::stAcquire);
    assign sampleAccept = wrEn && acqActive;

    // scanner read port, combinational
    assign scanCount = binCount[scanAddr];

    always_ff @(posedge clk) begin
        if (rst) begin
            state          <= sifhPkg::stAcquire;
            acceptCount    <= '0;
            acqCountFinish <= 1'b0;
            hisNum         <= 1'b0;
        end else begin
            acqCountFinish <= 1'b0;
            case (state)
                sifhPkg::stAcquire: begin
                    if (sampleAccept) begin
                        acceptCount <= acceptCount + 1'b1;
                        // 64th accept closes the pass
                        if (acceptCount == sifhPkg::lastAccept) begin
                            state <= sifhPkg::stDrain;
                        end
                    end
                end
                sifhPkg::stDrain: begin
                    // last sample's increment lands on this edge
                    acqCountFinish <= 1'b1;
                    acceptCount    <= '0;
                    state          <= sifhPkg::stWaitPeak;
                end
                sifhPkg::stWaitPeak: begin
                    if (peakDone) begin
                        // coarse -> fine, fine -> new coarse run
                        hisNum <= !hisNum;
                        state  <= sifhPkg::stArm;
                    end
                end
                default: begin
                    // one idle cycle, window start settles
                    state <= sifhPkg::stAcquire;
                end
            endcase
        end
    end

    // bin counters
    // increments only while filling, clears only while scanning
    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < sifhPkg::numBins; i++) begin
                binCount[i] <= '0;
            end
        end else begin
            if (binValid) begin
                binCount[binIdx] <= binCount[binIdx] + 1'b1;
            end
            if (scanClear) begin
                binCount[scanAddr] <= '0;
            end
        end
    end

endmodule

`default_nettype wire

// ==== source/peakDetecter.sv ====
`default_nettype none

module peakDetecter (
    input  wire logic                               clk,
    input  wire logic                               rst,
    input  wire logic                               acqCountFinish,
    output logic      [sifhPkg::binIdxWidth-1:0]    scanAddr,
    output logic                                    scanClear,
    input  wire logic [sifhPkg::peakMax-1:0]        scanCount,
    input  wire logic                               hisNum,
    output logic                                    peakDone,
    output logic      [sifhPkg::binIdxWidth-1:0]    peakIdx,
    output logic      [sifhPkg::binIdxWidth-1:0]    peakCH,
    output logic      [sifhPkg::binIdxWidth-1:0]    peakFH
);

    logic                               scanBusy;
    logic                               reading;
    logic                               lastRead;
    logic                               takeNew;
    logic [sifhPkg::peakMax-1:0]        runMax;
    logic [sifhPkg::binIdxWidth-1:0]    runIdx;
    logic [sifhPkg::binIdxWidth-1:0]    winner;

    // bin 0 read in the acqCountFinish cycle itself
    assign reading   = acqCountFinish || scanBusy;
    assign scanClear = reading;
    assign lastRead  = reading && (scanAddr == sifhPkg::lastBin);

    // strictly greater, so lowest index keeps a tie
    // first bin always loads, all-zero gives bin 0
    assign takeNew = acqCountFinish || (scanCount > runMax);
    assign winner  = takeNew ? scanAddr : runIdx;

    always_ff @(posedge clk) begin
        if (rst) begin
            scanAddr <= '0;
            scanBusy <= 1'b0;
            peakDone <= 1'b0;
            peakIdx  <= '0;
            peakCH   <= '0;
            peakFH   <= '0;
        end else begin
            peakDone <= 1'b0;
            if (reading) begin
                // wraps back to 0 after bin 15
                scanAddr <= scanAddr + 1'b1;
                scanBusy <= !lastRead;
            end
            if (lastRead) begin
                peakDone <= 1'b1;
                peakIdx  <= winner;
                if (hisNum) begin
                    peakFH <= winner;
                end else begin
                    peakCH <= winner;
                end
            end
        end
    end

    // running maximum, only meaningful during a scan
    always_ff @(posedge clk) begin
        if (reading && takeNew) begin
            runMax <= scanCount;
            runIdx <= scanAddr;
        end
    end

endmodule

`default_nettype wire

// ==== source/sifhPkg.sv ====
`default_nettype none

package sifhPkg;

    // timestamp and histogram geometry
    localparam int stampWidth    = 10;
    localparam int numBins       = 16;
    localparam int binIdxWidth   = 4;
    localparam int peakMax       = 8;
    localparam int samplesPerHis = 64;

    // bin widths as powers of two
    localparam int coarseShift = 6;
    localparam int fineShift   = 3;

    // fine window placement
    localparam int windowSpan = 128;
    localparam int windowBack = 32;
    // keeps window start + span inside the code range
    localparam int windowMax  = (1 << stampWidth) - windowSpan;

    // bits above the fine bin that must be zero for an in-window sample
    localparam int excessWidth = stampWidth - binIdxWidth - fineShift;

    localparam logic [binIdxWidth-1:0] lastBin = binIdxWidth'(numBins - 1);

    // accept counter, reaches samplesPerHis
    localparam int acceptWidth = 7;
    localparam logic [acceptWidth-1:0] lastAccept = acceptWidth'(samplesPerHis - 1);

    // hisBuilderFSM states
    localparam logic [1:0] stAcquire  = 2'd0;
    localparam logic [1:0] stDrain    = 2'd1;
    localparam logic [1:0] stWaitPeak = 2'd2;
    localparam logic [1:0] stArm      = 2'd3;

    // coarse decode of the offset word
    typedef struct packed {
        logic                   borrow;
        logic [binIdxWidth-1:0] bin;
        logic [coarseShift-1:0] rem;
    } coarseView_t;

    // fine decode, excess set means past the window end
    typedef struct packed {
        logic                   borrow;
        logic [excessWidth-1:0] excess;
        logic [binIdxWidth-1:0] bin;
        logic [fineShift-1:0]   rem;
    } fineView_t;

    // timestamp minus window start, borrow on top
    typedef union packed {
        logic [stampWidth:0] word;
        coarseView_t         coarseView;
        fineView_t           fineView;
    } offsetWord_t;

endpackage

`default_nettype wire

// ==== source/sifhTop.sv ====
`default_nettype none

module sifhTop (
    input  wire logic                               clk,
    input  wire logic                               rst,
    input  wire logic                               wrEn,
    input  wire logic [sifhPkg::stampWidth-1:0]     roughData,
    output logic                                    acqActive,
    output logic                                    hisNum,
    output logic                                    acqCountFinish,
    output logic      [sifhPkg::binIdxWidth-1:0]    peakCH,
    output logic      [sifhPkg::binIdxWidth-1:0]    peakFH,
    output logic      [sifhPkg::stampWidth-1:0]     windowStart,
    output logic      [sifhPkg::stampWidth-1:0]     peakStamp,
    output logic                                    resultValid
);

    // mapper <-> counters
    logic                               sampleAccept;
    logic                               binValid;
    logic [sifhPkg::binIdxWidth-1:0]    binIdx;

    // scanner read-and-clear port
    logic [sifhPkg::binIdxWidth-1:0]    scanAddr;
    logic                               scanClear;
    logic [sifhPkg::peakMax-1:0]        scanCount;

    // peak result
    logic                               peakDone;
    logic [sifhPkg::binIdxWidth-1:0]    peakIdx;

    binMapper binMapperU0 (
        .clk          (clk),
        .rst          (rst),
        .sampleAccept (sampleAccept),
        .roughData    (roughData),
        .windowStart  (windowStart),
        .hisNum       (hisNum),
        .binValid     (binValid),
        .binIdx       (binIdx)
    );

    hisBuilderFSM hisBuilderFSMU0 (
        .clk            (clk),
        .rst            (rst),
        .wrEn           (wrEn),
        .acqActive      (acqActive),
        .sampleAccept   (sampleAccept),
        .binValid       (binValid),
        .binIdx         (binIdx),
        .acqCountFinish (acqCountFinish),
        .hisNum         (hisNum),
        .scanAddr       (scanAddr),
        .scanClear      (scanClear),
        .scanCount      (scanCount),
        .peakDone       (peakDone)
    );

    peakDetecter peakDetecterU0 (
        .clk            (clk),
        .rst            (rst),
        .acqCountFinish (acqCountFinish),
        .scanAddr       (scanAddr),
        .scanClear      (scanClear),
        .scanCount      (scanCount),
        .hisNum         (hisNum),
        .peakDone       (peakDone),
        .peakIdx        (peakIdx),
        .peakCH         (peakCH),
        .peakFH         (peakFH)
    );

    algebraicBlock algebraicBlockU0 (
        .clk         (clk),
        .rst         (rst),
        .peakDone    (peakDone),
        .hisNum      (hisNum),
        .peakIdx     (peakIdx),
        .windowStart (windowStart),
        .peakStamp   (peakStamp),
        .resultValid (resultValid)
    );

endmodule

`default_nettype wire

// ==== verification/clockGen.sv ====
`default_nettype none

module clockGen (
    output logic clk
);
    timeunit 1ns;
    timeprecision 100ps;

    // half of the 20 ns period
    localparam int halfPeriod = 10;

    initial begin
        clk = 1'b0;
        forever #(halfPeriod) clk = ~clk;
    end

endmodule

`default_nettype wire

// ==== verification/sifhTb.sv ====
`default_nettype none

module sifhTb;
    timeunit 1ns;
    timeprecision 100ps;

    localparam int resetCycles = 10;
    localparam int numRuns     = 12;
    localparam int runCycles   = 400;
    localparam int cycleLimit  = numRuns * runCycles + resetCycles;
    localparam int numTests    = 6;

    logic                               clk;
    logic                               rst;
    logic                               wrEn;
    logic [sifhPkg::stampWidth-1:0]     roughData;
    logic                               acqActive;
    logic                               hisNum;
    logic                               acqCountFinish;
    logic [sifhPkg::binIdxWidth-1:0]    peakCH;
    logic [sifhPkg::binIdxWidth-1:0]    peakFH;
    logic [sifhPkg::stampWidth-1:0]     windowStart;
    logic [sifhPkg::stampWidth-1:0]     peakStamp;
    logic                               resultValid;

    integer seed;
    int     cycleCount = 0;
    int     checkCount [numTests];
    int     errorCount [numTests];
    string  testName [numTests];

    // model state, accepted stamps of the current run
    logic [sifhPkg::stampWidth-1:0] coarseStamp [$];
    logic [sifhPkg::stampWidth-1:0] fineStamp [$];
    int acceptCount;
    bit lastActive;

    clockGen clockGenU0 (.clk(clk));

    sifhTop DUT (
        .clk            (clk),
        .rst            (rst),
        .wrEn           (wrEn),
        .roughData      (roughData),
        .acqActive      (acqActive),
        .hisNum         (hisNum),
        .acqCountFinish (acqCountFinish),
        .peakCH         (peakCH),
        .peakFH         (peakFH),
        .windowStart    (windowStart),
        .peakStamp      (peakStamp),
        .resultValid    (resultValid)
    );

    // hang guard
    always @(posedge clk) begin
        cycleCount++;
        if (cycleCount > cycleLimit) begin
            $display("timeout: no end of test after %0d cycles", cycleLimit);
            $display("TEST FAILED");
            $finish;
        end
    end

    // negative owner keeps the default test slot
    function automatic int slotFor(input int owner, input int slot);
        return (owner < 0) ? slot : owner;
    endfunction

    function automatic int randomCentre();
        return $unsigned($random(seed)) % (1 << sifhPkg::stampWidth);
    endfunction

    // centre +-20, one in eight uniform outliers
    function automatic logic [sifhPkg::stampWidth-1:0] makeStamp(input int centre);
        int value;
        if (($unsigned($random(seed)) % 8) == 0) begin
            value = $unsigned($random(seed)) % (1 << sifhPkg::stampWidth);
        end else begin
            value = centre + ($random(seed) % 21);
        end
        if (value < 0) begin
            value = 0;
        end
        if (value > (1 << sifhPkg::stampWidth) - 1) begin
            value = (1 << sifhPkg::stampWidth) - 1;
        end
        return sifhPkg::stampWidth'(value);
    endfunction

    // lowest index wins a tie
    function automatic int pickPeak(input int hist [sifhPkg::numBins]);
        int best;
        best = 0;
        for (int i = 1; i < sifhPkg::numBins; i++) begin
            if (hist[i] > hist[best]) begin
                best = i;
            end
        end
        return best;
    endfunction

    function automatic int modelCoarsePeak();
        int hist [sifhPkg::numBins];
        sifhPkg::offsetWord_t offset;
        foreach (hist[i]) begin
            hist[i] = 0;
        end
        foreach (coarseStamp[k]) begin
            offset.word = {1'b0, coarseStamp[k]};
            hist[offset.coarseView.bin]++;
        end
        return pickPeak(hist);
    endfunction

    // window sits 32 codes before the coarse bin, kept inside the code range
    function automatic int modelWindow(input int coarsePeak);
        int start;
        start = (coarsePeak << sifhPkg::coarseShift) - sifhPkg::windowBack;
        if (start < 0) begin
            start = 0;
        end
        if (start > sifhPkg::windowMax) begin
            start = sifhPkg::windowMax;
        end
        return start;
    endfunction

    // out-of-window stamps are dropped
    function automatic int modelFinePeak(input int window);
        int hist [sifhPkg::numBins];
        sifhPkg::offsetWord_t offset;
        foreach (hist[i]) begin
            hist[i] = 0;
        end
        foreach (fineStamp[k]) begin
            offset.word = {1'b0, fineStamp[k]} - (sifhPkg::stampWidth + 1)'(window);
            if (!offset.fineView.borrow && (offset.fineView.excess == '0)) begin
                hist[offset.fineView.bin]++;
            end
        end
        return pickPeak(hist);
    endfunction

    task automatic checkValue(input int test, input string name, input int expected,
                              input int actual);
        checkCount[test]++;
        if (actual != expected) begin
            errorCount[test]++;
            $display("FAILED at %0t: %s expected %0d, got %0d", $time, name, expected, actual);
        end
    endtask

    // one falling edge: inputs change here, outputs are stable
    task automatic driveCycle(input int centre, input int owner);
        bit active;
        bit strobe;
        @(negedge clk);
        active = acqActive;
        if (active && !lastActive) begin
            acceptCount = 0;
        end
        // pass must close on exactly 64 accepts
        if (!active && lastActive) begin
            checkValue(slotFor(owner, 3), "acqActive fall, accepted count",
                       sifhPkg::samplesPerHis, acceptCount);
        end
        lastActive = active;
        // strays while acqActive is low use the same rate
        strobe    = (($unsigned($random(seed)) % 10) < 7);
        wrEn      = strobe;
        roughData = makeStamp(centre);
        if (strobe && active) begin
            acceptCount++;
            if (hisNum) begin
                fineStamp.push_back(roughData);
            end else begin
                coarseStamp.push_back(roughData);
            end
        end
    endtask

    // one coarse and one fine pass, checked at resultValid
    task automatic runOnce(input int centre, input int owner);
        int expCoarse;
        int expWindow;
        int expFine;
        int expStamp;
        bit done;
        coarseStamp.delete();
        fineStamp.delete();
        done = 1'b0;
        while (!done) begin
            driveCycle(centre, owner);
            if (resultValid) begin
                done      = 1'b1;
                expCoarse = modelCoarsePeak();
                expWindow = modelWindow(expCoarse);
                expFine   = modelFinePeak(expWindow);
                expStamp  = expWindow + (expFine << sifhPkg::fineShift) +
                            (1 << (sifhPkg::fineShift - 1));
                checkValue(slotFor(owner, 0), "peakCH", expCoarse, peakCH);
                checkValue(slotFor(owner, 1), "windowStart", expWindow, windowStart);
                checkValue(slotFor(owner, 2), "peakFH", expFine, peakFH);
                checkValue(slotFor(owner, 2), "peakStamp", expStamp, peakStamp);
                // next run begins in the coarse pass
                checkValue(slotFor(owner, 4), "hisNum", 0, hisNum);
            end
        end
    endtask

    task automatic resetDuringFine(input int centre);
        coarseStamp.delete();
        fineStamp.delete();
        while (fineStamp.size() < 20) begin
            driveCycle(centre, 5);
        end
        @(negedge clk);
        rst  = 1'b1;
        wrEn = 1'b0;
        repeat (resetCycles) @(negedge clk);
        checkValue(5, "hisNum", 0, hisNum);
        checkValue(5, "acqActive", 1, acqActive);
        checkValue(5, "acqCountFinish", 0, acqCountFinish);
        checkValue(5, "resultValid", 0, resultValid);
        checkValue(5, "peakCH", 0, peakCH);
        checkValue(5, "peakFH", 0, peakFH);
        checkValue(5, "windowStart", 0, windowStart);
        checkValue(5, "peakStamp", 0, peakStamp);
        rst        = 1'b0;
        lastActive = 1'b0;
    endtask

    task automatic reportTest(input int test);
        if (checkCount[test] == 0) begin
            errorCount[test]++;
            $display("%s: no checks were made", testName[test]);
        end else begin
            $display("%s: %0d checks, %0d errors", testName[test], checkCount[test],
                     errorCount[test]);
        end
    endtask

    initial begin
        int totalChecks;
        int totalErrors;
        int assertFails;
        seed        = 10504;
        testName[0] = "coarse peak";
        testName[1] = "window clamp";
        testName[2] = "fine peak and result";
        testName[3] = "ignored strobes";
        testName[4] = "back-to-back runs";
        testName[5] = "reset mid-pass";
        foreach (checkCount[i]) begin
            checkCount[i] = 0;
            errorCount[i] = 0;
        end
        rst         = 1'b1;
        wrEn        = 1'b0;
        roughData   = '0;
        lastActive  = 1'b0;
        acceptCount = 0;
        repeat (resetCycles) @(negedge clk);
        rst = 1'b0;

        // bin boundary, low clamp, high clamp
        runOnce(512, -1);
        runOnce(6, -1);
        runOnce(1017, -1);
        repeat (6) runOnce(randomCentre(), -1);
        for (int t = 0; t < 5; t++) begin
            reportTest(t);
        end

        resetDuringFine(randomCentre());
        runOnce(randomCentre(), 5);
        reportTest(5);

        totalChecks = 0;
        totalErrors = 0;
        foreach (checkCount[i]) begin
            totalChecks += checkCount[i];
            totalErrors += errorCount[i];
        end
        assertFails = DUT.sifhTopAssertU0.failCount;
        $display("total: %0d checks, %0d errors, %0d assertion failures",
                 totalChecks, totalErrors, assertFails);
        if (totalErrors == 0 && assertFails == 0) begin
            $display("TEST OK");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== verification/sifhTop_assert.sv ====
`default_nettype none

module sifhTopAssert (
    input wire logic clk,
    input wire logic rst,
    input wire logic acqActive,
    input wire logic hisNum,
    input wire logic acqCountFinish,
    input wire logic resultValid,
    input wire logic peakDone
);
    timeunit 1ns;
    timeprecision 100ps;

    // read by the testbench at the end of the run
    int failCount = 0;

    finishPulse: assert property (@(posedge clk) disable iff (rst)
        acqCountFinish |=> !acqCountFinish)
        else begin
            failCount++;
            $error("acqCountFinish held for more than one cycle");
        end

    resultPulse: assert property (@(posedge clk) disable iff (rst)
        resultValid |=> !resultValid)
        else begin
            failCount++;
            $error("resultValid held for more than one cycle");
        end

    // sampling stopped while the scan runs
    idleAtFinish: assert property (@(posedge clk) disable iff (rst)
        acqCountFinish |-> !acqActive)
        else begin
            failCount++;
            $error("acqActive high during acqCountFinish");
        end

    // acquisition re-arms only right after a pass change
    riseAfterSwap: assert property (@(posedge clk) disable iff (rst)
        $rose(acqActive) |-> ($past(hisNum) != $past(hisNum, 2)))
        else begin
            failCount++;
            $error("acqActive rose without a preceding hisNum change");
        end

    swapAfterPeak: assert property (@(posedge clk) disable iff (rst)
        $changed(hisNum) |-> $past(peakDone))
        else begin
            failCount++;
            $error("hisNum changed without peakDone in the cycle before");
        end

endmodule

bind sifhTop sifhTopAssert sifhTopAssertU0 (
    .clk            (clk),
    .rst            (rst),
    .acqActive      (acqActive),
    .hisNum         (hisNum),
    .acqCountFinish (acqCountFinish),
    .resultValid    (resultValid),
    .peakDone       (peakDone)
);

`default_nettype wire
